// ==== src/engine_cfg_pkg.sv ====
`default_nettype none

// Word, address and counter sizes shared by the datapath and the sequencer
package engine_cfg_pkg;

	localparam int PARA       = 16;              // Lanes per channel group
	localparam int WORD_W     = 16;              // Data and weight word width
	localparam int ADDR_W     = 30;              // DMA word address width
	localparam int CNT_W      = 16;              // Loop counter width
	localparam int LANE_CNT_W = $clog2(PARA) + 1; // Holds 0 to PARA

	typedef logic [WORD_W-1:0] word_t;     // One data or weight word
	typedef logic [ADDR_W-1:0] addr_t;     // DMA word address
	typedef logic [CNT_W-1:0]  cnt_t;      // Channel, side and point counts

	// One channel group, lane 0 in the low word
	typedef word_t [PARA-1:0] lane_vec_t;

	typedef logic [LANE_CNT_W-1:0] lane_cnt_t; // Valid lanes in a group

endpackage

`default_nettype wire

// ==== src/engine_ctrl_pkg.sv ====
`default_nettype none

// Sequencer states and fixed engine limits
package engine_ctrl_pkg;

	typedef enum logic [1:0] {
		IDLE  = 2'd0, // Waiting for a start pulse
		FETCH = 2'd1, // Groups being requested and collected
		DRAIN = 2'd2, // Everything fetched, final write still open
		DONE  = 2'd3  // One-cycle finish
	} state_t;

	// Largest output side, same bound as the old per-point sum array
	localparam int MAX_SIDE = 128;

endpackage

`default_nettype wire

// ==== src/operand_if.sv ====
`default_nettype none

// One channel group of operands on its way from fetch to the MAC lanes
interface operand_if;

	logic                      valid;  // One-cycle group strobe
	engine_cfg_pkg::lane_vec_t data;   // Input channel words
	engine_cfg_pkg::lane_vec_t weight; // Matching weights
	logic                      first;  // First group of a point
	logic                      last;   // Last group of a point

	// Fetch side, sequencer drives the strobe and flags, collectors the vectors
	modport producer (
		output valid,
		output data,
		output weight,
		output first,
		output last
	);

	modport consumer (
		input valid,
		input data,
		input weight,
		input first,
		input last
	);

endinterface

`default_nettype wire

// ==== src/burst_deser.sv ====
`default_nettype none

// Turns one serial DMA burst into a PARA-lane vector
module burst_deser (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            i_start_burst, // Goes with the read request
	input  wire engine_cfg_pkg::lane_cnt_t i_len,         // Words in this burst
	input  wire                            i_we,          // DMA word strobe
	input  wire engine_cfg_pkg::word_t     i_word,
	output engine_cfg_pkg::lane_vec_t      o_vec,
	output logic                           o_full
);

	localparam int IDX_W = engine_cfg_pkg::LANE_CNT_W - 1; // Bits to address a lane

	engine_cfg_pkg::lane_cnt_t idx; // Next free lane

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
		end else if (i_start_burst) begin
			idx <= '0; // Restart for the new burst
		end else if (i_we) begin
			idx <= idx + 1'b1;
		end
	end

	// Lanes above the burst length keep their zero from the clear
	always_ff @(posedge clk) begin
		if (i_start_burst) begin
			o_vec <= '0;
		end else if (i_we) begin
			o_vec[idx[IDX_W-1:0]] <= i_word;
		end
	end

	assign o_full = (idx == i_len); // Every requested word is in

	// DMA must send exactly the requested count
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		(o_full && !i_start_burst) |-> !i_we);

endmodule

`default_nettype wire

// ==== src/layer_ctrl.sv ====
`default_nettype none

// Walks groups, points and output channels and issues the read bursts
module layer_ctrl (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            i_start,
	input  wire engine_cfg_pkg::cnt_t      i_i_channel,
	input  wire engine_cfg_pkg::cnt_t      i_o_side,
	input  wire engine_cfg_pkg::cnt_t      i_o_channel,
	input  wire engine_cfg_pkg::addr_t     i_data_addr,
	input  wire engine_cfg_pkg::addr_t     i_wt_addr,
	input  wire engine_cfg_pkg::addr_t     i_res_addr,
	output logic                           o_data_rd_en,
	output engine_cfg_pkg::addr_t          o_data_addr,
	output logic                           o_wt_rd_en,
	output engine_cfg_pkg::addr_t          o_wt_addr,
	output engine_cfg_pkg::lane_cnt_t      o_burst_len,
	output logic                           o_start_burst,
	output engine_cfg_pkg::addr_t          o_res_addr,    // Result address of the point
	input  wire                            i_data_full,
	input  wire                            i_wt_full,
	input  wire                            i_busy,        // Writer holds a result
	input  wire                            i_last_written, // Write-back pulse
	output logic                           o_engine_ready,
	operand_if.producer                    op
);

	engine_ctrl_pkg::state_t state;

	// Layer settings, kept for the whole layer
	engine_cfg_pkg::cnt_t  c_num, side, oc_num;
	engine_cfg_pkg::addr_t data_start;

	// Address blocks for the current point and output channel
	engine_cfg_pkg::addr_t data_block, wt_block, res_block;

	engine_cfg_pkg::cnt_t offset; // Channel offset of the group, 16g
	engine_cfg_pkg::cnt_t rem;    // Channels left in this point
	engine_cfg_pkg::cnt_t pt;     // Output point
	engine_cfg_pkg::cnt_t oc;     // Output channel

	logic pending;    // Bursts requested, group not yet handed on
	logic all_issued; // Final group of the layer requested
	logic wr_owed;    // Last group on its way, writer not yet loaded

	logic last_grp, pt_wrap, oc_wrap, can_issue, grp_ready;

	assign last_grp = (rem <= engine_cfg_pkg::cnt_t'(engine_cfg_pkg::PARA));
	assign pt_wrap  = (pt == side - 1'b1);
	assign oc_wrap  = (oc == oc_num - 1'b1);

	// One write slot only, so a last group waits for a free writer
	assign can_issue = (state == engine_ctrl_pkg::FETCH) && !pending && !all_issued
		&& !(last_grp && (i_busy || wr_owed));

	// Both collectors full, start cycle masks the stale count
	assign grp_ready = pending && !o_start_burst && i_data_full && i_wt_full;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state         <= engine_ctrl_pkg::IDLE;
			o_data_rd_en  <= 1'b0;
			o_wt_rd_en    <= 1'b0;
			o_start_burst <= 1'b0;
			op.valid      <= 1'b0;
			op.first      <= 1'b0;
			op.last       <= 1'b0;
			pending       <= 1'b0;
			all_issued    <= 1'b0;
			wr_owed       <= 1'b0;
			offset        <= '0;
			rem           <= '0;
			pt            <= '0;
			oc            <= '0;
		end else begin
			o_data_rd_en  <= can_issue; // Request pulses
			o_wt_rd_en    <= can_issue;
			o_start_burst <= can_issue;
			op.valid      <= grp_ready; // One cycle after the later burst
			if (i_busy)
				wr_owed <= 1'b0; // Result reached the writer
			case (state)
				engine_ctrl_pkg::IDLE: begin
					if (i_start) begin
						state      <= engine_ctrl_pkg::FETCH;
						offset     <= '0;
						rem        <= i_i_channel;
						pt         <= '0;
						oc         <= '0;
						all_issued <= 1'b0;
					end
				end
				engine_ctrl_pkg::FETCH: begin
					if (grp_ready)
						pending <= 1'b0;
					if (can_issue) begin
						pending  <= 1'b1;
						op.first <= (offset == '0);
						op.last  <= last_grp;
						if (last_grp) begin
							wr_owed <= 1'b1;
							offset  <= '0; // Next point starts at channel 0
							rem     <= c_num;
							pt      <= pt_wrap ? '0 : pt + 1'b1;
							if (pt_wrap) begin
								oc <= oc + 1'b1; // Next weight set
								if (oc_wrap)
									all_issued <= 1'b1;
							end
						end else begin
							offset <= offset + engine_cfg_pkg::cnt_t'(engine_cfg_pkg::PARA);
							rem    <= rem - engine_cfg_pkg::cnt_t'(engine_cfg_pkg::PARA);
						end
					end
					if (all_issued && !pending)
						state <= engine_ctrl_pkg::DRAIN; // Final group handed on
				end
				engine_ctrl_pkg::DRAIN: begin
					if (i_last_written)
						state <= engine_ctrl_pkg::DONE;
				end
				default: state <= engine_ctrl_pkg::IDLE; // DONE lasts one cycle
			endcase
		end
	end

	// Settings and burst addresses
	always_ff @(posedge clk) begin
		if (state == engine_ctrl_pkg::IDLE && i_start) begin
			c_num      <= i_i_channel;
			side       <= i_o_side;
			oc_num     <= i_o_channel;
			data_start <= i_data_addr;
			data_block <= i_data_addr;
			wt_block   <= i_wt_addr;
			res_block  <= i_res_addr;
		end else if (can_issue) begin
			o_data_addr <= data_block + engine_cfg_pkg::addr_t'(offset);
			o_wt_addr   <= wt_block + engine_cfg_pkg::addr_t'(offset);
			o_burst_len <= last_grp ? engine_cfg_pkg::lane_cnt_t'(rem)
				: engine_cfg_pkg::lane_cnt_t'(engine_cfg_pkg::PARA);
			if (last_grp) begin
				o_res_addr <= res_block + engine_cfg_pkg::addr_t'(pt);
				data_block <= pt_wrap ? data_start
					: data_block + engine_cfg_pkg::addr_t'(c_num); // Next point row
				if (pt_wrap) begin
					wt_block  <= wt_block + engine_cfg_pkg::addr_t'(c_num);
					res_block <= res_block + engine_cfg_pkg::addr_t'(side);
				end
			end
		end
	end

	assign o_engine_ready = (state == engine_ctrl_pkg::DONE);

	a_rd_in_fetch: assert property (@(posedge clk) disable iff (rst)
		(o_data_rd_en || o_wt_rd_en) |-> state == engine_ctrl_pkg::FETCH);

	a_side_limit: assert property (@(posedge clk) disable iff (rst)
		(i_start && state == engine_ctrl_pkg::IDLE)
		|-> i_o_side <= engine_cfg_pkg::cnt_t'(engine_ctrl_pkg::MAX_SIDE));

endmodule

`default_nettype wire

// ==== src/mac_lanes.sv ====
`default_nettype none

// PARA multipliers, one per lane, with a register stage behind them
module mac_lanes (
	input  wire                       clk,
	input  wire                       rst,
	operand_if.consumer               op,
	output engine_cfg_pkg::lane_vec_t o_prod,       // Truncated products
	output logic                      o_prod_valid,
	output logic                      o_first,
	output logic                      o_last
);

	// Group flags follow the products by one cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_prod_valid <= 1'b0;
			o_first      <= 1'b0;
			o_last       <= 1'b0;
		end else begin
			o_prod_valid <= op.valid;
			o_first      <= op.first;
			o_last       <= op.last;
		end
	end

	// Low 16 bits of each product
	always_ff @(posedge clk) begin
		if (op.valid) begin
			for (int i = 0; i < engine_cfg_pkg::PARA; i++) begin
				o_prod[i] <= op.data[i] * op.weight[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/channel_accum.sv ====
`default_nettype none

// Adds the lanes of a group and carries the sum across groups of one point
module channel_accum (
	input  wire                            clk,
	input  wire                            rst,
	input  wire engine_cfg_pkg::lane_vec_t i_prod,
	input  wire                            i_prod_valid,
	input  wire                            i_first,
	input  wire                            i_last,
	output engine_cfg_pkg::word_t          o_result,
	output logic                           o_result_valid
);

	engine_cfg_pkg::word_t lane_sum; // Sum over the lanes of one group
	engine_cfg_pkg::word_t acc;      // Running sum of the point
	engine_cfg_pkg::word_t next_acc;

	// Zeroed upper lanes add nothing on a short group
	always_comb begin
		lane_sum = '0;
		for (int i = 0; i < engine_cfg_pkg::PARA; i++) begin
			lane_sum = lane_sum + i_prod[i];
		end
	end

	// First group restarts the point, wraps at 16 bits
	assign next_acc = i_first ? lane_sum : acc + lane_sum;

	always_ff @(posedge clk) begin
		if (i_prod_valid)
			acc <= next_acc;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_result_valid <= 1'b0;
		else
			o_result_valid <= i_prod_valid && i_last; // Point complete
	end

	// Held until the next group of the following point
	assign o_result = acc;

endmodule

`default_nettype wire

// ==== src/result_writer.sv ====
`default_nettype none

// Single-entry write-back buffer toward the DMA write port
module result_writer (
	input  wire                        clk,
	input  wire                        rst,
	input  wire engine_cfg_pkg::word_t i_result,
	input  wire                        i_result_valid,
	input  wire engine_cfg_pkg::addr_t i_res_addr,
	output logic                       o_wr_en,    // Level until the read answer
	output engine_cfg_pkg::addr_t      o_wr_addr,
	input  wire                        i_wr_re,    // DMA takes the word
	output logic                       o_wr_valid, // Word on o_wr_data
	output engine_cfg_pkg::word_t      o_wr_data,
	output logic                       o_busy
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_wr_en    <= 1'b0;
			o_wr_valid <= 1'b0;
		end else begin
			o_wr_valid <= o_wr_en && i_wr_re; // Data follows the answer
			if (i_result_valid)
				o_wr_en <= 1'b1;
			else if (i_wr_re)
				o_wr_en <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_result_valid) begin
			o_wr_addr <= i_res_addr;
			o_wr_data <= i_result;
		end
	end

	assign o_busy = o_wr_en || o_wr_valid; // Slot taken until the data goes out

	// DMA answers only a write that is still pending
	a_re_while_en: assert property (@(posedge clk) disable iff (rst)
		i_wr_re |-> o_wr_en);

	// Sequencer throttling must keep the slot free for every result
	a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
		i_result_valid |-> !o_busy);

endmodule

`default_nettype wire

// ==== src/conv_engine.sv ====
`default_nettype none

// 1x1 convolution layer engine on DMA-style read and write ports
module conv_engine (
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        i_start,
	input  wire engine_cfg_pkg::cnt_t  i_i_channel,
	input  wire engine_cfg_pkg::cnt_t  i_o_side,
	input  wire engine_cfg_pkg::cnt_t  i_o_channel,
	input  wire engine_cfg_pkg::addr_t i_data_addr,
	input  wire engine_cfg_pkg::addr_t i_wt_addr,
	input  wire engine_cfg_pkg::addr_t i_res_addr,
	output logic                       o_data_rd_en,
	output engine_cfg_pkg::addr_t      o_data_addr,
	output logic                       o_wt_rd_en,
	output engine_cfg_pkg::addr_t      o_wt_addr,
	output engine_cfg_pkg::lane_cnt_t  o_burst_len,
	input  wire                        i_data_we,
	input  wire engine_cfg_pkg::word_t i_data,
	input  wire                        i_wt_we,
	input  wire engine_cfg_pkg::word_t i_wt,
	output logic                       o_wr_en,
	output engine_cfg_pkg::addr_t      o_wr_addr,
	input  wire                        i_wr_re,
	output logic                       o_wr_valid,
	output engine_cfg_pkg::word_t      o_wr_data,
	output logic                       o_engine_ready
);

	logic                      start_burst, data_full, wt_full, busy;
	engine_cfg_pkg::addr_t     res_addr;
	engine_cfg_pkg::lane_vec_t prod;
	logic                      prod_valid, prod_first, prod_last;
	engine_cfg_pkg::word_t     result;
	logic                      result_valid;

	operand_if u_op ();

	layer_ctrl u_ctrl (
		.clk(clk), .rst(rst),
		.i_start(i_start), .i_i_channel(i_i_channel), .i_o_side(i_o_side),
		.i_o_channel(i_o_channel), .i_data_addr(i_data_addr), .i_wt_addr(i_wt_addr),
		.i_res_addr(i_res_addr),
		.o_data_rd_en(o_data_rd_en), .o_data_addr(o_data_addr),
		.o_wt_rd_en(o_wt_rd_en), .o_wt_addr(o_wt_addr),
		.o_burst_len(o_burst_len), .o_start_burst(start_burst), .o_res_addr(res_addr),
		.i_data_full(data_full), .i_wt_full(wt_full), .i_busy(busy),
		.i_last_written(o_wr_valid), .o_engine_ready(o_engine_ready),
		.op(u_op.producer)
	);

	// Data and weight collectors share the burst length
	burst_deser u_data_deser (
		.clk(clk), .rst(rst), .i_start_burst(start_burst), .i_len(o_burst_len),
		.i_we(i_data_we), .i_word(i_data), .o_vec(u_op.data), .o_full(data_full)
	);

	burst_deser u_wt_deser (
		.clk(clk), .rst(rst), .i_start_burst(start_burst), .i_len(o_burst_len),
		.i_we(i_wt_we), .i_word(i_wt), .o_vec(u_op.weight), .o_full(wt_full)
	);

	mac_lanes u_mac (
		.clk(clk), .rst(rst), .op(u_op.consumer), .o_prod(prod),
		.o_prod_valid(prod_valid), .o_first(prod_first), .o_last(prod_last)
	);

	channel_accum u_accum (
		.clk(clk), .rst(rst), .i_prod(prod), .i_prod_valid(prod_valid),
		.i_first(prod_first), .i_last(prod_last),
		.o_result(result), .o_result_valid(result_valid)
	);

	result_writer u_writer (
		.clk(clk), .rst(rst), .i_result(result), .i_result_valid(result_valid),
		.i_res_addr(res_addr), .o_wr_en(o_wr_en), .o_wr_addr(o_wr_addr),
		.i_wr_re(i_wr_re), .o_wr_valid(o_wr_valid), .o_wr_data(o_wr_data),
		.o_busy(busy)
	);

endmodule

`default_nettype wire

// ==== dv/dma_model.sv ====
`default_nettype none

// DMA side of the engine with data and weight memories and the write answer
module dma_model (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            i_slow,       // Long gaps between words
	input  wire                            i_data_rd_en,
	input  wire engine_cfg_pkg::addr_t     i_data_addr,
	input  wire                            i_wt_rd_en,
	input  wire engine_cfg_pkg::addr_t     i_wt_addr,
	input  wire engine_cfg_pkg::lane_cnt_t i_burst_len,
	output wire                            o_data_we,
	output wire engine_cfg_pkg::word_t     o_data,
	output wire                            o_wt_we,
	output wire engine_cfg_pkg::word_t     o_wt,
	input  wire                            i_wr_en,
	output wire                            o_wr_re
);

	localparam int MEM_N = 4096; // Word addresses wrap here

	engine_cfg_pkg::word_t data_mem [MEM_N];
	engine_cfg_pkg::word_t wt_mem [MEM_N];
	int data_q [$]; // Addresses still owed on the data port
	int wt_q [$];

	logic                  data_we = 1'b0;
	engine_cfg_pkg::word_t data_word = '0;
	logic                  wt_we = 1'b0;
	engine_cfg_pkg::word_t wt_word = '0;
	logic                  wr_re = 1'b0;
	int                    wr_wait = -1; // Cycles before the answer, -1 when not armed

	assign o_data_we = data_we;
	assign o_data    = data_word;
	assign o_wt_we   = wt_we;
	assign o_wt      = wt_word;
	assign o_wr_re   = wr_re;

	// Random contents, called once the seed is set
	task automatic fill_mem();
		for (int i = 0; i < MEM_N; i++) begin
			data_mem[i] = engine_cfg_pkg::word_t'($urandom);
			wt_mem[i]   = engine_cfg_pkg::word_t'($urandom);
		end
	endtask

	// Idle cycle draw, mostly idle in slow mode
	function automatic bit skip_cycle();
		int r;
		r = $urandom_range(0, 3);
		return i_slow ? (r != 0) : (r == 0);
	endfunction

	always @(negedge clk) begin
		if (rst) begin
			data_we <= 1'b0;
			wt_we   <= 1'b0;
			wr_re   <= 1'b0;
			data_q.delete();
			wt_q.delete();
			wr_wait = -1;
		end else begin
			// Only words of earlier requests, never in the request cycle itself
			if (data_q.size() > 0 && !skip_cycle()) begin
				data_we   <= 1'b1;
				data_word <= data_mem[data_q.pop_front()];
			end else begin
				data_we <= 1'b0;
			end
			if (wt_q.size() > 0 && !skip_cycle()) begin
				wt_we   <= 1'b1;
				wt_word <= wt_mem[wt_q.pop_front()];
			end else begin
				wt_we <= 1'b0;
			end
			if (i_data_rd_en)
				for (int i = 0; i < int'(i_burst_len); i++)
					data_q.push_back((int'(i_data_addr) + i) % MEM_N); // Ascending burst
			if (i_wt_rd_en)
				for (int i = 0; i < int'(i_burst_len); i++)
					wt_q.push_back((int'(i_wt_addr) + i) % MEM_N);
			// One answer per write enable period, 0 to 4 cycles late
			if (wr_re) begin
				wr_re   <= 1'b0;
				wr_wait = -1;
			end else if (i_wr_en) begin
				if (wr_wait < 0)
					wr_wait = $urandom_range(0, 4);
				if (wr_wait == 0)
					wr_re <= 1'b1;
				wr_wait = wr_wait - 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== dv/tb_conv_engine.sv ====
`default_nettype none

// Testbench for the 1x1 convolution engine, DMA model plus result checker
module tb_conv_engine;

	logic                  clk = 1'b0;
	logic                  rst = 1'b1;
	logic                  i_start = 1'b0;
	engine_cfg_pkg::cnt_t  i_i_channel = '0;
	engine_cfg_pkg::cnt_t  i_o_side = '0;
	engine_cfg_pkg::cnt_t  i_o_channel = '0;
	engine_cfg_pkg::addr_t i_data_addr = '0;
	engine_cfg_pkg::addr_t i_wt_addr = '0;
	engine_cfg_pkg::addr_t i_res_addr = '0;
	logic                  slow = 1'b0; // Long read gaps in the model

	wire                            data_rd_en, wt_rd_en, data_we, wt_we;
	wire                            wr_en, wr_re, wr_valid, engine_ready;
	wire engine_cfg_pkg::addr_t     data_addr, wt_addr, wr_addr;
	wire engine_cfg_pkg::lane_cnt_t burst_len;
	wire engine_cfg_pkg::word_t     data_word, wt_word, wr_data;

	// Current layer, for the reference and the request checks
	int cfg_c, cfg_side, cfg_ocn, cfg_data, cfg_wt, cfg_res;

	int   val_errs = 0;
	int   proto_errs = 0;
	int   timeouts = 0;
	int   wr_count = 0;
	int   ready_count = 0;
	logic wr_en_q = 1'b0; // Write enable one cycle back

	always #5 clk = ~clk;

	conv_engine u_dut (
		.clk(clk), .rst(rst), .i_start(i_start),
		.i_i_channel(i_i_channel), .i_o_side(i_o_side), .i_o_channel(i_o_channel),
		.i_data_addr(i_data_addr), .i_wt_addr(i_wt_addr), .i_res_addr(i_res_addr),
		.o_data_rd_en(data_rd_en), .o_data_addr(data_addr),
		.o_wt_rd_en(wt_rd_en), .o_wt_addr(wt_addr), .o_burst_len(burst_len),
		.i_data_we(data_we), .i_data(data_word), .i_wt_we(wt_we), .i_wt(wt_word),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .i_wr_re(wr_re),
		.o_wr_valid(wr_valid), .o_wr_data(wr_data), .o_engine_ready(engine_ready)
	);

	dma_model u_dma (
		.clk(clk), .rst(rst), .i_slow(slow),
		.i_data_rd_en(data_rd_en), .i_data_addr(data_addr),
		.i_wt_rd_en(wt_rd_en), .i_wt_addr(wt_addr), .i_burst_len(burst_len),
		.o_data_we(data_we), .o_data(data_word), .o_wt_we(wt_we), .o_wt(wt_word),
		.i_wr_en(wr_en), .o_wr_re(wr_re)
	);

	// Channel dot product of point x and output channel oc, full sum cut to 16 bits
	function automatic engine_cfg_pkg::word_t ref_result(input int oc, input int x);
		int unsigned acc;
		int unsigned d;
		int unsigned w;
		acc = 0;
		for (int c = 0; c < cfg_c; c++) begin
			d   = 32'(u_dma.data_mem[cfg_data + x * cfg_c + c]);
			w   = 32'(u_dma.wt_mem[cfg_wt + oc * cfg_c + c]);
			acc = acc + d * w;
		end
		return engine_cfg_pkg::word_t'(acc);
	endfunction

	// Burst length from the group offset, weight request in step with data
	task automatic check_request();
		int off;
		int exp_len;
		off     = (int'(data_addr) - cfg_data) % cfg_c;
		exp_len = (cfg_c - off < engine_cfg_pkg::PARA) ? cfg_c - off : engine_cfg_pkg::PARA;
		if (int'(burst_len) != exp_len) begin
			$display("[FAIL] t=%0t o_burst_len: got %0d expected %0d", $time, burst_len, exp_len);
			val_errs++;
		end
		if (!wt_rd_en || (int'(wt_addr) - cfg_wt) % cfg_c != off) begin
			$display("Weight request at %0t does not match the data request", $time);
			proto_errs++;
		end
	endtask

	task automatic check_write();
		int                    exp_addr;
		engine_cfg_pkg::word_t exp_data;
		if (wr_count >= cfg_side * cfg_ocn) begin
			$display("Extra write at %0t after every result of the layer", $time);
			proto_errs++;
		end else begin
			exp_addr = cfg_res + wr_count; // Output channel major, points in order
			exp_data = ref_result(wr_count / cfg_side, wr_count % cfg_side);
			if (int'(wr_addr) != exp_addr) begin
				$display("[FAIL] t=%0t o_wr_addr: got %h expected %h", $time, wr_addr, exp_addr);
				val_errs++;
			end
			if (wr_data != exp_data) begin
				$display("[FAIL] t=%0t o_wr_data: got %h expected %h", $time, wr_data, exp_data);
				val_errs++;
			end
		end
		wr_count++;
	endtask

	// Compare process, outputs are settled at the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (data_rd_en)
				check_request();
			if (wr_valid)
				check_write();
			if (wr_en_q && !wr_re && !wr_en) begin
				$display("Write enable dropped at %0t before the read answer", $time);
				proto_errs++;
			end
			if (wr_valid && !(wr_en_q && wr_re)) begin
				$display("Write data at %0t without a read answer before it", $time);
				proto_errs++;
			end
			if (engine_ready) begin
				ready_count++;
				if (wr_count != cfg_side * cfg_ocn) begin
					$display("Engine ready at %0t after %0d of %0d writes", $time, wr_count,
						cfg_side * cfg_ocn);
					proto_errs++;
				end
			end
		end
		wr_en_q = wr_en;
	end

	task automatic run_layer(input int c, input int side, input int ocn,
			input int d, input int w, input int r, input bit s);
		int cycles;
		cfg_c       = c;
		cfg_side    = side;
		cfg_ocn     = ocn;
		cfg_data    = d;
		cfg_wt      = w;
		cfg_res     = r;
		wr_count    = 0;
		ready_count = 0;
		slow        <= s; // Model reads it on the same edge
		@(negedge clk);
		i_start     = 1'b1;
		i_i_channel = engine_cfg_pkg::cnt_t'(c);
		i_o_side    = engine_cfg_pkg::cnt_t'(side);
		i_o_channel = engine_cfg_pkg::cnt_t'(ocn);
		i_data_addr = engine_cfg_pkg::addr_t'(d);
		i_wt_addr   = engine_cfg_pkg::addr_t'(w);
		i_res_addr  = engine_cfg_pkg::addr_t'(r);
		@(negedge clk);
		i_start = 1'b0;
		cycles  = 0;
		while (ready_count == 0 && cycles < 20000) begin
			@(negedge clk);
			cycles++;
		end
		if (ready_count == 0) begin
			$display("Timeout: layer with %0d channels never reported ready", c);
			timeouts++;
		end else begin
			for (int i = 0; i < 6; i++)
				@(negedge clk); // Room for a stray second ready or write
			if (wr_count != side * ocn || ready_count != 1) begin
				$display("Layer with %0d channels ended with %0d writes and %0d ready pulses",
					c, wr_count, ready_count);
				proto_errs++;
			end
		end
	endtask

	initial begin
		void'($urandom(32'hb5d5_cc82));
		u_dma.fill_mem();
		for (int i = 0; i < 3; i++)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		run_layer(16, 4, 2, 'h010, 'h800, 'h100, 1'b0); // Single group
		if (timeouts == 0)
			run_layer(40, 3, 2, 'h080, 'h900, 'h200, 1'b0); // Short last group
		if (timeouts == 0)
			run_layer(5, 6, 3, 'h120, 'ha00, 'h300, 1'b0);  // Fewer than PARA
		if (timeouts == 0)
			run_layer(20, 5, 3, 'h1a0, 'hb00, 'h400, 1'b1); // Slow reads
		if (timeouts == 0)
			run_layer(33, 4, 2, 'h300, 'hc00, 'h500, 1'b0); // Back to back layer
		$display("Errors: %0d value, %0d protocol, %0d timeout", val_errs, proto_errs, timeouts);
		if (val_errs + proto_errs + timeouts == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
src/engine_cfg_pkg.sv
src/engine_ctrl_pkg.sv
src/operand_if.sv
src/burst_deser.sv
src/layer_ctrl.sv
src/mac_lanes.sv
src/channel_accum.sv
src/result_writer.sv
src/conv_engine.sv
dv/dma_model.sv
dv/tb_conv_engine.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the conv engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module tb_conv_engine -Mdir obj_dir -f src.f \
	|| { echo "Build failed"; exit 1; }
./obj_dir/Vtb_conv_engine > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
